//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // one access from a requester, or on the external bus
    typedef struct packed {
        // read strobe, held until busy drops
        logic        ren;
        // write strobe, held until busy drops
        logic        wen;
        // byte address
        logic [31:0] addr;
        logic [31:0] wdata;
        // one bit per byte lane of wdata
        logic [3:0]  byte_en;
    } gen_bus_req_t;

    // reply side of the same bus
    typedef struct packed {
        // valid in the cycle busy is low with a raised request
        logic [31:0] rdata;
        // high while the access is still in progress
        logic        busy;
        // access failed, qualified like rdata
        logic        error;
    } gen_bus_rsp_t;

    // 2 strobes + 32 addr + 32 data + 4 byte enables
    localparam int GEN_BUS_REQ_W = $bits(gen_bus_req_t);

    // 32 data + busy + error
    localparam int GEN_BUS_RSP_W = $bits(gen_bus_rsp_t);

endpackage

`default_nettype wire

//--- verilog/mc_pkg.sv
`default_nettype none

package mc_pkg;

    // controller sequencing, exactly one transaction in flight
    typedef enum logic [1:0] {
        L2_IDLE   = 2'd0,
        L2_ACCESS = 2'd1,
        L2_RETURN = 2'd2
    } l2_state_t;

    // life of one captured access inside a front side port
    typedef enum logic [1:0] {
        FS_IDLE  = 2'd0,
        FS_PEND  = 2'd1,
        FS_GRANT = 2'd2,
        FS_DONE  = 2'd3
    } fs_state_t;

    // result held by the controller between translator done and port done
    typedef struct packed {
        logic [31:0] rdata;
        logic        error;
    } mc_result_t;

endpackage

`default_nettype wire

//--- verilog/front_side_port.sv
`timescale 1ns/1ps
`default_nettype none

module front_side_port
    import bus_pkg::*;
    import mc_pkg::*;
(
    input  logic         CLK,
    input  logic         rst,
    input  gen_bus_req_t req,
    output gen_bus_rsp_t rsp,
    input  logic         abort,
    output gen_bus_req_t pend_req,
    output logic         pend,
    input  logic         granted,
    input  logic         done,
    input  logic [31:0]  done_rdata,
    input  logic         done_error
);

    fs_state_t    state_q;
    gen_bus_req_t req_q;
    logic [31:0]  rdata_q;
    logic         error_q;
    logic         req_raised;

    assign req_raised = req.ren | req.wen;

    // state of the captured access
    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q <= FS_IDLE;
        end else begin
            case (state_q)
                FS_IDLE: begin
                    // abort before capture completes straight away as an error
                    if (req_raised) begin
                        state_q <= abort ? FS_DONE : FS_PEND;
                    end
                end
                // a grant wins over an abort in the same cycle
                FS_PEND: begin
                    if (granted) begin
                        state_q <= FS_GRANT;
                    end else if (abort) begin
                        state_q <= FS_DONE;
                    end
                end
                FS_GRANT: begin
                    if (done) begin
                        state_q <= FS_DONE;
                    end
                end
                // completion cycle, requester may drop or change the request
                default: state_q <= FS_IDLE;
            endcase
        end
    end

    // captured request and returned data
    always_ff @(posedge CLK) begin
        if (state_q == FS_IDLE && req_raised) begin
            req_q   <= req;
            error_q <= abort;
        end else if (state_q == FS_PEND && !granted && abort) begin
            error_q <= 1'b1;
        end else if (state_q == FS_GRANT && done) begin
            rdata_q <= done_rdata;
            error_q <= done_error;
        end
    end

    assign pend_req = req_q;
    assign pend     = (state_q == FS_PEND);

    // busy from the raise until the done cycle
    assign rsp.busy  = req_raised && (state_q != FS_DONE);
    assign rsp.rdata = rdata_q;
    // error only qualified in the completion cycle
    assign rsp.error = (state_q == FS_DONE) && error_q;

endmodule

`default_nettype wire

//--- verilog/memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

module memory_controller
    import bus_pkg::*;
    import mc_pkg::*;
#(
    parameter int NUM_HARTS = 2,
    localparam int NUM_PORTS = 2 * NUM_HARTS
) (
    input  logic                         CLK,
    input  logic                         rst,
    input  gen_bus_req_t [NUM_PORTS-1:0] pend_req,
    input  logic [NUM_PORTS-1:0]         pend,
    output logic [NUM_PORTS-1:0]         granted,
    output logic [NUM_PORTS-1:0]         done,
    output logic [31:0]                  rsp_rdata,
    output logic                         rsp_error,
    output gen_bus_req_t                 bt_req,
    output logic                         bt_start,
    input  logic                         bt_done,
    input  logic [31:0]                  bt_rdata,
    input  logic                         bt_error
);

    // index width for 2 to 8 ports
    localparam int PW = $clog2(NUM_PORTS);

    l2_state_t  state_q;
    logic [PW-1:0] ptr_q;
    logic [PW-1:0] sel_q;
    logic [PW-1:0] pick;
    logic          found;
    mc_result_t    result_q;

    // round robin, search starts at the pointer and wraps
    always_comb begin
        int idx;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!found && pend[idx]) begin
                found = 1'b1;
                pick  = idx[PW-1:0];
            end
        end
    end

    // grant and start share the idle cycle
    assign bt_start = (state_q == L2_IDLE) && found;
    assign bt_req   = pend_req[pick];

    always_comb begin
        granted = '0;
        if (bt_start) begin
            granted[pick] = 1'b1;
        end
    end

    // one-hot completion back to the served port
    always_comb begin
        done = '0;
        if (state_q == L2_RETURN) begin
            done[sel_q] = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q <= L2_IDLE;
            ptr_q   <= '0;
            sel_q   <= '0;
        end else begin
            case (state_q)
                L2_IDLE: begin
                    if (found) begin
                        state_q <= L2_ACCESS;
                        sel_q   <= pick;
                        // next search starts after the port just granted
                        ptr_q   <= (pick == PW'(NUM_PORTS - 1)) ? '0 : pick + PW'(1);
                    end
                end
                // wait on the translator, ext busy stalls here
                L2_ACCESS: begin
                    if (bt_done) begin
                        state_q <= L2_RETURN;
                    end
                end
                default: state_q <= L2_IDLE;
            endcase
        end
    end

    // translator result held for the return cycle
    always_ff @(posedge CLK) begin
        if (state_q == L2_ACCESS && bt_done) begin
            result_q.rdata <= bt_rdata;
            result_q.error <= bt_error;
        end
    end

    assign rsp_rdata = result_q.rdata;
    assign rsp_error = result_q.error;

endmodule

`default_nettype wire

//--- verilog/generic_nonpipeline.sv
`timescale 1ns/1ps
`default_nettype none

module generic_nonpipeline
    import bus_pkg::*;
(
    input  logic         CLK,
    input  logic         rst,
    input  gen_bus_req_t req,
    input  logic         start,
    output logic         done,
    output logic [31:0]  rdata,
    output logic         error,
    output gen_bus_req_t ext_req,
    input  gen_bus_rsp_t ext_rsp
);

    // transaction currently driven on the external bus
    logic         active_q;
    gen_bus_req_t req_q;
    logic         done_q;
    logic [31:0]  rdata_q;
    logic         error_q;
    logic         ext_complete;

    // memory drops busy in the last cycle of the access
    assign ext_complete = active_q && !ext_rsp.busy;

    always_ff @(posedge CLK) begin
        if (rst) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= ext_complete;
            if (start && !active_q) begin
                active_q <= 1'b1;
            end else if (ext_complete) begin
                active_q <= 1'b0;
            end
        end
    end

    // payload captured at start, result at completion
    always_ff @(posedge CLK) begin
        if (start && !active_q) begin
            req_q <= req;
        end
        if (ext_complete) begin
            rdata_q <= ext_rsp.rdata;
            error_q <= ext_rsp.error;
        end
    end

    // strobes only while the transaction is open
    always_comb begin
        ext_req     = req_q;
        ext_req.ren = active_q && req_q.ren;
        ext_req.wen = active_q && req_q.wen;
    end

    assign done  = done_q;
    assign rdata = rdata_q;
    assign error = error_q;

endmodule

`default_nettype wire

//--- verilog/multicore_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module multicore_mem_top
    import bus_pkg::*;
#(
    parameter int NUM_HARTS = 2,
    localparam int NUM_PORTS = 2 * NUM_HARTS
) (
    input  logic                         CLK,
    input  logic                         rst,
    input  gen_bus_req_t [NUM_PORTS-1:0] fs_req,
    output gen_bus_rsp_t [NUM_PORTS-1:0] fs_rsp,
    input  logic [NUM_HARTS-1:0]         abort,
    input  logic [NUM_HARTS-1:0]         hart_halt,
    output logic                         halt,
    output gen_bus_req_t                 ext_req,
    input  gen_bus_rsp_t                 ext_rsp
);

    // port to controller
    gen_bus_req_t [NUM_PORTS-1:0] pend_req;
    logic [NUM_PORTS-1:0]         pend;
    logic [NUM_PORTS-1:0]         granted;
    logic [NUM_PORTS-1:0]         done;
    logic [31:0]                  rsp_rdata;
    logic                         rsp_error;

    // controller to translator
    gen_bus_req_t bt_req;
    logic         bt_start;
    logic         bt_done;
    logic [31:0]  bt_rdata;
    logic         bt_error;

    // whole system halts only when every hart has
    assign halt = &hart_halt;

    // port 2h is the instruction side of hart h, 2h+1 the data side
    genvar p;
    generate
        for (p = 0; p < NUM_PORTS; p++) begin : g_port
            front_side_port fsp (
                .CLK        (CLK),
                .rst        (rst),
                .req        (fs_req[p]),
                .rsp        (fs_rsp[p]),
                .abort      (abort[p / 2]),
                .pend_req   (pend_req[p]),
                .pend       (pend[p]),
                .granted    (granted[p]),
                .done       (done[p]),
                .done_rdata (rsp_rdata),
                .done_error (rsp_error)
            );
        end
    endgenerate

    memory_controller #(
        .NUM_HARTS (NUM_HARTS)
    ) mc (
        .CLK       (CLK),
        .rst       (rst),
        .pend_req  (pend_req),
        .pend      (pend),
        .granted   (granted),
        .done      (done),
        .rsp_rdata (rsp_rdata),
        .rsp_error (rsp_error),
        .bt_req    (bt_req),
        .bt_start  (bt_start),
        .bt_done   (bt_done),
        .bt_rdata  (bt_rdata),
        .bt_error  (bt_error)
    );

    // generic bus variant of the output side
    generic_nonpipeline bt (
        .CLK     (CLK),
        .rst     (rst),
        .req     (bt_req),
        .start   (bt_start),
        .done    (bt_done),
        .rdata   (bt_rdata),
        .error   (bt_error),
        .ext_req (ext_req),
        .ext_rsp (ext_rsp)
    );

endmodule

`default_nettype wire

//--- test/gen_bus_mem.sv
`timescale 1ns/1ps
`default_nettype none

module gen_bus_mem
    import bus_pkg::*;
(
    input  logic         CLK,
    input  logic         rst,
    input  gen_bus_req_t req,
    output gen_bus_rsp_t rsp
);

    // sparse word store, keyed by word address
    logic [31:0] mem [logic [29:0]];
    // wait cycles left before the current access completes
    logic [1:0]  wait_q;
    logic        raised;
    logic        err_region;
    logic [29:0] key;

    assign raised     = req.ren | req.wen;
    assign key        = req.addr[31:2];
    // top nibble F is unmapped
    assign err_region = (req.addr[31:28] == 4'hf);

    // never written words read back a pattern built from the whole address
    function automatic logic [31:0] stored_word(logic [29:0] k);
        return mem.exists(k) ? mem[k] : ({k, 2'b00} ^ 32'hc3a5_1e0f);
    endfunction

    always_comb begin
        rsp.busy  = raised && (wait_q != 2'd0);
        rsp.error = raised && err_region;
        rsp.rdata = (req.ren && !err_region) ? stored_word(key) : 32'h0;
    end

    // next wait count drawn in each completion cycle
    always_ff @(posedge CLK) begin
        if (rst) begin
            wait_q <= 2'd0;
        end else if (raised) begin
            wait_q <= (wait_q != 2'd0) ? wait_q - 2'd1 : 2'($urandom_range(3));
        end
    end

    // byte lane merge, error region left untouched
    always @(posedge CLK) begin
        logic [31:0] w;
        if (!rst && req.wen && wait_q == 2'd0 && !err_region) begin
            w = stored_word(key);
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b]) begin
                    w[8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
            mem[key] = w;
        end
    end

endmodule

`default_nettype wire

//--- test/multicore_mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module multicore_mem_props
    import mc_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input logic                 CLK,
    input logic                 rst,
    input logic [NUM_PORTS-1:0] granted,
    input logic [NUM_PORTS-1:0] done,
    input logic                 bt_start,
    input l2_state_t            state
);

    // at most one port owns the transaction path
    a_grant_onehot: assert property (@(posedge CLK) disable iff (rst) $onehot0(granted))
        else $error("granted is not one-hot or zero: %b", granted);

    // new transactions start only from idle
    a_start_idle: assert property (@(posedge CLK) disable iff (rst)
        bt_start |-> state == L2_IDLE)
        else $error("bt_start raised in state %0d", state);

    // port completion only in the return cycle
    a_done_return: assert property (@(posedge CLK) disable iff (rst)
        (|done) |-> state == L2_RETURN)
        else $error("done %b raised in state %0d", done, state);

endmodule

bind memory_controller multicore_mem_props #(
    .NUM_PORTS (NUM_PORTS)
) i_props (
    .CLK      (CLK),
    .rst      (rst),
    .granted  (granted),
    .done     (done),
    .bt_start (bt_start),
    .state    (state_q)
);

`default_nettype wire

//--- test/multicore_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module multicore_mem_tb
    import bus_pkg::*;
();

    localparam int NUM_HARTS  = 2;
    localparam int NUM_PORTS  = 2 * NUM_HARTS;
    localparam int CLK_PERIOD = 4;
    localparam int N_RAND     = 16;
    // random writes and reads, two full rounds, error region, abort group
    localparam int NUM_ACCESSES = 2 * N_RAND + 2 * NUM_PORTS + 3 + 3;

    // one finished access as seen by its requester
    typedef struct packed {
        logic [1:0]   port;
        logic         aborted;
        gen_bus_req_t req;
        logic [31:0]  rdata;
        logic         error;
    } completion_t;

    logic                         CLK;
    logic                         rst;
    gen_bus_req_t [NUM_PORTS-1:0] fs_req;
    gen_bus_rsp_t [NUM_PORTS-1:0] fs_rsp;
    logic [NUM_HARTS-1:0]         abort;
    logic [NUM_HARTS-1:0]         hart_halt;
    logic                         halt;
    gen_bus_req_t                 ext_req;
    gen_bus_rsp_t                 ext_rsp;

    completion_t cq[$];
    // port order of granted completions
    logic [1:0]  order_q[$];
    logic [31:0] shadow [logic [29:0]];
    logic [31:0] banned_addr;
    logic        banned_valid;
    int          mismatches = 0;
    int          failures = 0;
    int          checked = 0;

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    multicore_mem_top #(
        .NUM_HARTS (NUM_HARTS)
    ) i_dut (
        .CLK       (CLK),
        .rst       (rst),
        .fs_req    (fs_req),
        .fs_rsp    (fs_rsp),
        .abort     (abort),
        .hart_halt (hart_halt),
        .halt      (halt),
        .ext_req   (ext_req),
        .ext_rsp   (ext_rsp)
    );

    gen_bus_mem i_mem (
        .CLK (CLK),
        .rst (rst),
        .req (ext_req),
        .rsp (ext_rsp)
    );

    function automatic gen_bus_req_t make_req(logic wr, logic [31:0] addr,
                                              logic [31:0] wdata, logic [3:0] be);
        gen_bus_req_t r;
        r.ren     = !wr;
        r.wen     = wr;
        r.addr    = addr;
        r.wdata   = wdata;
        r.byte_en = be;
        return r;
    endfunction

    // memory content before an access, unwritten words follow the fill pattern
    function automatic logic [31:0] shadow_word(logic [31:0] addr);
        return shadow.exists(addr[31:2]) ? shadow[addr[31:2]]
                                         : ({addr[31:2], 2'b00} ^ 32'hc3a5_1e0f);
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] wdata,
                                                logic [3:0] be);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    // reference reply, reads return the stored word, top nibble F fails
    function automatic gen_bus_rsp_t expect_rsp(gen_bus_req_t req, logic [31:0] old_word);
        gen_bus_rsp_t r;
        r.busy  = 1'b0;
        r.error = (req.addr[31:28] == 4'hf);
        r.rdata = (req.ren && !r.error) ? old_word : 32'h0;
        return r;
    endfunction

    // raise on the falling edge, hold until busy is seen low at a falling edge
    task automatic access(input int port, input gen_bus_req_t req, input logic aborted);
        completion_t c;
        int          waited;
        @(negedge CLK);
        fs_req[port] = req;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (fs_rsp[port].busy);
        c.port    = 2'(port);
        c.aborted = aborted;
        c.req     = req;
        c.rdata   = fs_rsp[port].rdata;
        c.error   = fs_rsp[port].error;
        cq.push_back(c);
        if (!aborted) begin
            order_q.push_back(2'(port));
        end
        assert (aborted || waited >= 5) else begin
            failures++;
            $display("%0t: port %0d completed after only %0d cycles", $time, port, waited);
        end
        @(negedge CLK);
        fs_req[port] = '0;
    endtask

    // every port at once, served from the port after the last one
    task automatic rr_round(input logic wr);
        int         base;
        logic [1:0] last;
        logic [1:0] exp_port;
        base = order_q.size();
        last = order_q[$];
        fork
            access(0, make_req(wr, 32'h0002_0000, $urandom, 4'hf), 1'b0);
            access(1, make_req(wr, 32'h0002_0004, $urandom, 4'hf), 1'b0);
            access(2, make_req(wr, 32'h0002_0008, $urandom, 4'hf), 1'b0);
            access(3, make_req(wr, 32'h0002_000c, $urandom, 4'hf), 1'b0);
        join
        for (int k = 0; k < NUM_PORTS; k++) begin
            exp_port = 2'(int'(last) + 1 + k);
            assert (order_q[base + k] == exp_port) else begin
                mismatches++;
                $display("MISMATCH %0t completion order[%0d] got port %0d exp port %0d",
                         $time, k, order_q[base + k], exp_port);
            end
        end
    endtask

    // completions pushed at falling edges, checked at the same or the next one
    always @(negedge CLK) begin : compare
        completion_t  c;
        gen_bus_rsp_t exp;
        logic [31:0]  old_word;
        while (cq.size() > 0) begin
            c = cq.pop_front();
            old_word = shadow_word(c.req.addr);
            exp = expect_rsp(c.req, old_word);
            if (c.aborted) begin
                assert (c.error) else begin
                    failures++;
                    $display("%0t: aborted access on port %0d ended without error",
                             $time, c.port);
                end
            end else begin
                assert (c.error == exp.error) else begin
                    mismatches++;
                    $display("MISMATCH %0t fs_rsp[%0d].error got %0b exp %0b",
                             $time, c.port, c.error, exp.error);
                end
                assert (c.rdata == exp.rdata) else begin
                    mismatches++;
                    $display("MISMATCH %0t fs_rsp[%0d].rdata got %h exp %h",
                             $time, c.port, c.rdata, exp.rdata);
                end
                if (c.req.wen && !exp.error) begin
                    shadow[c.req.addr[31:2]] = merge_bytes(old_word, c.req.wdata,
                                                           c.req.byte_en);
                end
            end
            checked++;
        end
    end

    // aborted address must never reach the memory
    always @(negedge CLK) begin
        if (banned_valid && (ext_req.ren || ext_req.wen)) begin
            assert (ext_req.addr != banned_addr) else begin
                failures++;
                $display("%0t: aborted address %h reached the external bus", $time, banned_addr);
            end
        end
    end

    initial begin : watchdog
        #(NUM_ACCESSES * 40 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_ACCESSES * 40);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addrs [N_RAND];
        logic [31:0] err_addr;
        void'($urandom(32'h14b1));
        rst          = 1'b1;
        fs_req       = '0;
        abort        = '0;
        hart_halt    = '0;
        banned_addr  = 32'h0003_0000;
        banned_valid = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        // quiet bus straight after reset
        @(negedge CLK);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (!fs_rsp[p].busy && !fs_rsp[p].error) else begin
                mismatches++;
                $display("MISMATCH %0t fs_rsp[%0d] busy/error got %0b/%0b exp 0/0",
                         $time, p, fs_rsp[p].busy, fs_rsp[p].error);
            end
        end
        assert (!ext_req.ren && !ext_req.wen) else begin
            mismatches++;
            $display("MISMATCH %0t ext_req ren/wen got %0b/%0b exp 0/0",
                     $time, ext_req.ren, ext_req.wen);
        end

        // halt sweep over every combination
        for (int h = 0; h < 4; h++) begin
            @(negedge CLK);
            hart_halt = 2'(h);
            @(posedge CLK);
            assert (halt == (hart_halt == 2'b11)) else begin
                mismatches++;
                $display("MISMATCH %0t halt got %0b exp %0b", $time, halt, hart_halt == 2'b11);
            end
        end

        // random partial writes, then read everything back
        for (int i = 0; i < N_RAND; i++) begin
            addrs[i] = {20'h00010, 8'(i), 2'($urandom_range(3)), 2'b00};
            access(int'($urandom_range(3)),
                   make_req(1'b1, addrs[i], $urandom, 4'($urandom_range(1, 15))), 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            access(int'($urandom_range(3)), make_req(1'b0, addrs[i], 32'h0, 4'hf), 1'b0);
        end

        rr_round(1'b1);
        rr_round(1'b0);

        // error region, then the same low bits outside it
        err_addr = {4'hf, addrs[0][27:0]};
        access(1, make_req(1'b1, err_addr, 32'h1234_5678, 4'hf), 1'b0);
        access(2, make_req(1'b0, err_addr, 32'h0, 4'hf), 1'b0);
        access(3, make_req(1'b0, addrs[0], 32'h0, 4'hf), 1'b0);

        // hart 1 data access queued behind hart 0, aborted before its grant
        banned_valid = 1'b1;
        fork
            access(0, make_req(1'b0, addrs[1], 32'h0, 4'hf), 1'b0);
            access(1, make_req(1'b0, addrs[2], 32'h0, 4'hf), 1'b0);
            begin
                @(negedge CLK);
                fork
                    access(3, make_req(1'b1, banned_addr, 32'hdead_0003, 4'hf), 1'b1);
                    begin
                        repeat (2) @(negedge CLK);
                        abort[1] = 1'b1;
                    end
                join
                abort[1] = 1'b0;
            end
        join

        repeat (2) @(negedge CLK);
        assert (checked == NUM_ACCESSES) else begin
            failures++;
            $display("only %0d of %0d accesses were checked", checked, NUM_ACCESSES);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- multicore_mem.f
verilog/bus_pkg.sv
verilog/mc_pkg.sv
verilog/front_side_port.sv
verilog/memory_controller.sv
verilog/generic_nonpipeline.sv
verilog/multicore_mem_top.sv
test/gen_bus_mem.sv
test/multicore_mem_props.sv
test/multicore_mem_tb.sv

//--- Makefile
# build and run of the multicore_mem testbench with Verilator

TOP := multicore_mem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f multicore_mem.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" sim.log; then echo "simulation ended without result"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only -Wall --top-module multicore_mem_top \
		verilog/bus_pkg.sv verilog/mc_pkg.sv verilog/front_side_port.sv \
		verilog/memory_controller.sv verilog/generic_nonpipeline.sv \
		verilog/multicore_mem_top.sv

clean:
	rm -rf obj_dir sim.log
